// File: run.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_frontend -f vlog.f -o tb_frontend

# assertion errors must not end the run before the testbench reports them
./obj_dir/tb_frontend +verilator+error+limit+100

// File: sim/frontend_assertions.sv
`timescale 1ns/1ps

module frontend_assertions #(
    parameter fetch_pkg::addr_t RESET_PC    = 32'h1c00_0000,
    parameter fetch_pkg::addr_t MEM_PATTERN = 32'h5ea1_c0de   // same as the memory model
) (
    input logic                           clk,
    input logic                           i_arst_n,
    input logic                           o_m_arvalid,
    input fetch_pkg::addr_t               o_m_araddr,
    input logic [7:0]                     o_m_arlen,
    input logic [2:0]                     o_m_arsize,
    input logic [1:0]                     o_m_arburst,
    input logic [fetch_pkg::AXI_ID_W-1:0] o_m_arid,
    input logic                           i_m_arready,
    input logic                           o_m_rready,
    input logic                           o_inst_valid,
    input logic                           i_inst_ready,
    input fetch_pkg::addr_t               o_inst_pc,
    input fetch_pkg::instr_t              o_inst0,
    input fetch_pkg::instr_t              o_inst1,
    input logic [1:0]                     o_slot_valid,
    input logic                           o_pred_taken,
    input fetch_pkg::addr_t               o_pred_target,
    input logic                           i_br_valid,
    input fetch_pkg::addr_t               i_br_pc,
    input fetch_pkg::addr_t               i_br_target,
    input logic                           i_br_taken,
    input logic                           i_br_mispredict
);
    import fetch_pkg::*;

    int    fail_count = 0;   // read by the testbench

    addr_t exp_pc_q;         // next pair the decoder should see
    logic  exp_slot0_q;
    logic  br_armed_q;       // a taken branch is in the BTB
    addr_t br_pc_q;
    addr_t br_tgt_q;

    logic  flush;
    logic  pop;
    logic  in_pair;
    addr_t redirect;

    assign flush    = i_br_valid & i_br_mispredict;
    assign pop      = o_inst_valid & i_inst_ready & ~flush;
    assign redirect = i_br_taken ? i_br_target : i_br_pc + 32'd4;
    // expected pair holds the branch in a valid slot
    assign in_pair  = br_armed_q && (exp_pc_q[31:3] == br_pc_q[31:3]) &&
                      (br_pc_q[2] || exp_slot0_q);

    ////////////////////////////////////////
    // expected pair stream
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            exp_pc_q    <= {RESET_PC[31:3], 3'b000};
            exp_slot0_q <= ~RESET_PC[2];
            br_armed_q  <= 1'b0;
            br_pc_q     <= '0;
            br_tgt_q    <= '0;
        end else begin
            if (flush) begin
                exp_pc_q    <= {redirect[31:3], 3'b000};
                exp_slot0_q <= ~redirect[2];
            end else if (pop && in_pair) begin
                exp_pc_q    <= {br_tgt_q[31:3], 3'b000};
                exp_slot0_q <= ~br_tgt_q[2];   // odd word target skips slot 0
            end else if (pop) begin
                exp_pc_q    <= exp_pc_q + 32'd8;
                exp_slot0_q <= 1'b1;
            end
            if (flush && i_br_taken) begin
                br_armed_q <= 1'b1;
                br_pc_q    <= i_br_pc;
                br_tgt_q   <= i_br_target;
            end else if (i_br_valid && !i_br_taken && i_br_pc == br_pc_q) begin
                br_armed_q <= 1'b0;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        !i_arst_n |-> !o_m_arvalid && !o_m_rready && !o_inst_valid)
        else begin fail_count++; $error("outputs active while reset is asserted"); end

    a_ar_stable: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_m_arvalid && !i_m_arready |=>
            o_m_arvalid && $stable(o_m_araddr) && $stable(o_m_arid))
        else begin fail_count++; $error("AR request changed before arready"); end

    a_ar_fields: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_m_arvalid |-> o_m_arlen == 8'd1 && o_m_arsize == 3'd2 &&
                        o_m_arburst == 2'b01 && o_m_araddr[2:0] == 3'b000)
        else begin fail_count++; $error("AR burst fields wrong or address not pair aligned"); end

    a_dec_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_inst_valid && !i_inst_ready && !flush |=>
            o_inst_valid && $stable(o_inst_pc) && $stable(o_inst0) && $stable(o_inst1) &&
            $stable(o_slot_valid) && $stable(o_pred_taken) && $stable(o_pred_target))
        else begin fail_count++; $error("decoder port changed while stalled"); end

    a_pair_pc: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_inst_valid |-> o_inst_pc == exp_pc_q)
        else begin
            fail_count++;
            $error("mismatch at %0t: o_inst_pc got %h expected %h",
                   $time, $sampled(o_inst_pc), $sampled(exp_pc_q));
        end

    a_slot0: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_inst_valid |-> o_slot_valid[0] == exp_slot0_q && (o_pred_taken || o_slot_valid[1]))
        else begin
            fail_count++;
            $error("mismatch at %0t: o_slot_valid got %b expected slot 0 %b",
                   $time, $sampled(o_slot_valid), $sampled(exp_slot0_q));
        end

    a_inst0: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_inst_valid |-> o_inst0 == (exp_pc_q ^ MEM_PATTERN))
        else begin
            fail_count++;
            $error("mismatch at %0t: o_inst0 got %h expected %h",
                   $time, $sampled(o_inst0), $sampled(exp_pc_q) ^ MEM_PATTERN);
        end

    a_inst1: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_inst_valid |-> o_inst1 == ((exp_pc_q + 32'd4) ^ MEM_PATTERN))
        else begin
            fail_count++;
            $error("mismatch at %0t: o_inst1 got %h expected %h",
                   $time, $sampled(o_inst1), ($sampled(exp_pc_q) + 32'd4) ^ MEM_PATTERN);
        end

    a_btb_predict: assert property (@(posedge clk) disable iff (!i_arst_n)
        o_inst_valid |-> o_pred_taken == in_pair &&
                         (!in_pair || o_pred_target == br_tgt_q))
        else begin
            fail_count++;
            $error("mismatch at %0t: o_pred_taken %b o_pred_target %h expected %b %h",
                   $time, $sampled(o_pred_taken), $sampled(o_pred_target),
                   $sampled(in_pair), $sampled(br_tgt_q));
        end

endmodule

bind frontend_top frontend_assertions #(.RESET_PC(RESET_PC)) u_checks (.*);

// File: sim/tb_frontend.sv
`timescale 1ns/1ps

module tb_frontend;
    import fetch_pkg::*;

    localparam addr_t RESET_PC         = 32'h1c00_0000;
    localparam addr_t MEM_PATTERN      = 32'h5ea1_c0de;
    localparam int    CYCLES_PER_PAIR  = 60;   // generous bound per delivered pair

    logic                clk;
    logic                i_arst_n;
    logic                o_m_arvalid;
    addr_t               o_m_araddr;
    logic [7:0]          o_m_arlen;
    logic [2:0]          o_m_arsize;
    logic [1:0]          o_m_arburst;
    logic [AXI_ID_W-1:0] o_m_arid;
    logic                i_m_arready;
    logic                i_m_rvalid;
    instr_t              i_m_rdata;
    logic                i_m_rlast;
    logic [AXI_ID_W-1:0] i_m_rid;
    logic                o_m_rready;
    logic                o_inst_valid;
    logic                i_inst_ready;
    addr_t               o_inst_pc;
    instr_t              o_inst0;
    instr_t              o_inst1;
    logic [1:0]          o_slot_valid;
    logic                o_pred_taken;
    addr_t               o_pred_target;
    logic                i_br_valid;
    addr_t               i_br_pc;
    addr_t               i_br_target;
    logic                i_br_taken;
    logic                i_br_mispredict;

    int   seed = 32'h3fe;
    logic stall_decoder;

    frontend_top #(.RESET_PC(RESET_PC)) u_dut (.*);

    function automatic int next_rand();
        return $random(seed);
    endfunction

    task automatic abort_run(input string reason);
        $display("%0t: %s", $time, reason);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    // count decoder handshakes, sampled mid cycle
    task automatic wait_pairs(input int count);
        int seen;
        int cycles;
        seen   = 0;
        cycles = 0;
        while (seen < count) begin
            @(negedge clk);
            if (o_inst_valid && i_inst_ready) seen++;
            cycles++;
            if (cycles > count * CYCLES_PER_PAIR) begin
                abort_run("timeout while waiting for fetch pairs at the decoder port");
            end
        end
    endtask

    // one cycle branch resolution with mispredict
    task automatic pulse_branch(input addr_t pc, input addr_t target, input logic taken);
        @(posedge clk);
        #1;
        i_br_valid      = 1'b1;
        i_br_pc         = pc;
        i_br_target     = target;
        i_br_taken      = taken;
        i_br_mispredict = 1'b1;
        @(posedge clk);
        #1;
        i_br_valid      = 1'b0;
        i_br_mispredict = 1'b0;
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////
    // AXI read slave, one burst at a time
    ////////////////////////////////////////
    initial begin : axi_memory
        bit                  ar_fire;
        bit                  r_fire;
        bit                  in_burst;
        int                  beat;
        addr_t               burst_addr;
        logic [AXI_ID_W-1:0] burst_id;
        i_m_arready = 1'b0;
        i_m_rvalid  = 1'b0;
        i_m_rdata   = '0;
        i_m_rlast   = 1'b0;
        i_m_rid     = '0;
        in_burst    = 1'b0;
        beat        = 0;
        burst_addr  = '0;
        burst_id    = '0;
        forever begin
            @(negedge clk);
            ar_fire = o_m_arvalid && i_m_arready;
            r_fire  = i_m_rvalid && o_m_rready;
            if (ar_fire) begin
                burst_addr = o_m_araddr;
                burst_id   = o_m_arid;
            end
            @(posedge clk);
            #1;
            if (ar_fire) begin
                in_burst = 1'b1;
                beat     = 0;
            end
            if (r_fire) begin
                beat++;
                if (beat == 2) in_burst = 1'b0;
            end
            i_m_arready = !in_burst && ((next_rand() & 3) != 0);
            if (!in_burst) begin
                i_m_rvalid = 1'b0;
                i_m_rlast  = 1'b0;
            end else if (!i_m_rvalid || r_fire) begin   // a pending beat stays put
                i_m_rvalid = (next_rand() & 3) != 0;
                i_m_rdata  = (burst_addr + (beat << 2)) ^ MEM_PATTERN;
                i_m_rlast  = (beat == 1);
                i_m_rid    = burst_id;
            end
        end
    end

    initial begin : decoder_ready
        i_inst_ready = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            i_inst_ready = !stall_decoder && ((next_rand() & 3) != 0);
        end
    end

    initial begin : assertion_watch
        forever begin
            @(negedge clk);
            if (u_dut.u_checks.fail_count != 0) begin
                abort_run("a front end assertion failed");
            end
        end
    end

    initial begin : main_sequence
        i_arst_n        = 1'b1;
        i_br_valid      = 1'b0;
        i_br_pc         = '0;
        i_br_target     = '0;
        i_br_taken      = 1'b0;
        i_br_mispredict = 1'b0;
        stall_decoder   = 1'b0;
        #2 i_arst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 i_arst_n = 1'b1;

        wait_pairs(12);                 // sequential stream from the reset PC
        stall_decoder = 1'b1;           // fill the queue
        repeat (40) @(posedge clk);
        stall_decoder = 1'b0;
        wait_pairs(8);

        // not taken redirect lands on an odd word
        pulse_branch(RESET_PC + 32'h40, RESET_PC + 32'h80, 1'b0);
        wait_pairs(6);

        // taken branch back into its own pair stream, loops on the BTB
        pulse_branch(RESET_PC + 32'h10c, RESET_PC + 32'h104, 1'b1);
        wait_pairs(10);
        pulse_branch(RESET_PC + 32'h10c, RESET_PC + 32'h104, 1'b0);
        wait_pairs(6);

        if (u_dut.u_checks.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            abort_run("assertion failures were reported");
        end
    end

endmodule

// File: source/axi_fetch.sv
`timescale 1ns/1ps

module axi_fetch (
    input  logic                            clk,
    input  logic                            i_arst_n,
    fetch_req_if.sink                       req,
    fetch_pair_if.src                       pair,
    input  logic                            i_flush,
    // AR channel
    output logic                            o_m_arvalid,
    output fetch_pkg::addr_t                o_m_araddr,
    output logic [7:0]                      o_m_arlen,
    output logic [2:0]                      o_m_arsize,
    output logic [1:0]                      o_m_arburst,
    output logic [fetch_pkg::AXI_ID_W-1:0]  o_m_arid,
    input  logic                            i_m_arready,
    // R channel
    input  logic                            i_m_rvalid,
    input  fetch_pkg::instr_t               i_m_rdata,
    input  logic                            i_m_rlast,
    input  logic [fetch_pkg::AXI_ID_W-1:0]  i_m_rid,
    output logic                            o_m_rready
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_HOLD
    } state_t;

    state_t      state_q;
    logic        drop_q;      // burst belongs to a flushed path
    logic        beat_q;      // 0 = first beat expected
    fetch_pair_t pair_q;

    logic        accept;
    logic        beat_ok;

    assign accept  = req.valid & req.ready;
    assign beat_ok = i_m_rvalid & o_m_rready & (i_m_rid == AXI_FETCH_ID);

    ////////////////////////////////////////
    // fetch FSM
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= S_IDLE;
            drop_q  <= 1'b0;
            beat_q  <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    drop_q <= 1'b0;
                    if (accept) begin
                        state_q <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    if (i_flush) begin
                        drop_q <= 1'b1;   // AR still has to complete
                    end
                    if (i_m_arready) begin
                        state_q <= S_DATA;
                    end
                end
                S_DATA: begin
                    if (i_flush) begin
                        drop_q <= 1'b1;
                    end
                    if (beat_ok) begin
                        beat_q <= ~i_m_rlast;
                        if (i_m_rlast) begin
                            state_q <= (drop_q | i_flush) ? S_IDLE : S_HOLD;
                            drop_q  <= 1'b0;
                        end
                    end
                end
                S_HOLD: begin
                    if (i_flush || pair.ready) begin
                        state_q <= S_IDLE;   // handed over or dropped
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // request capture and beat collection
    always_ff @(posedge clk) begin
        if (accept) begin
            pair_q.pc          <= {req.pc[31:3], 3'b000};
            pair_q.slot_valid  <= {1'b1, ~req.pc[2]};   // odd word skips slot 0
            pair_q.pred_taken  <= req.pred_taken;
            pair_q.pred_target <= req.pred_target;
            pair_q.pred_slot   <= req.pred_slot;
        end
        if (beat_ok) begin
            if (!beat_q) begin
                pair_q.inst0 <= i_m_rdata;
            end else begin
                pair_q.inst1 <= i_m_rdata;
            end
        end
    end

    assign req.ready   = (state_q == S_IDLE) & ~i_flush;
    assign pair.valid  = (state_q == S_HOLD);
    assign pair.pair   = pair_q;

    assign o_m_arvalid = (state_q == S_ADDR);
    assign o_m_araddr  = pair_q.pc;
    assign o_m_arlen   = AXI_PAIR_LEN;
    assign o_m_arsize  = AXI_SIZE_WORD;
    assign o_m_arburst = AXI_BURST_INCR;
    assign o_m_arid    = AXI_FETCH_ID;
    assign o_m_rready  = (state_q == S_DATA);

endmodule

// File: source/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor #(
    parameter int BTB_ENTRIES = 16
) (
    input  logic             clk,
    input  logic             i_arst_n,
    br_update_if.btb         br,
    input  fetch_pkg::addr_t i_lookup_pc,
    output logic             o_pred_hit,
    output fetch_pkg::addr_t o_pred_target,
    output logic             o_pred_slot
);
    import fetch_pkg::*;

    localparam int IDX_W = $clog2(BTB_ENTRIES);

    typedef logic [IDX_W-1:0]     idx_t;
    typedef logic [BTB_TAG_W-1:0] tag_t;

    logic [BTB_ENTRIES-1:0] valid_q;
    tag_t                   tag_mem    [BTB_ENTRIES];
    addr_t                  target_mem [BTB_ENTRIES];

    addr_t      slot_pc [2];
    logic [1:0] slot_hit;
    idx_t       upd_idx;
    tag_t       upd_tag;
    logic       upd_match;

    function automatic idx_t pc_idx(addr_t pc);
        return pc[BTB_IDX_LSB +: IDX_W];
    endfunction

    function automatic tag_t pc_tag(addr_t pc);
        return pc[BTB_IDX_LSB + IDX_W +: BTB_TAG_W];
    endfunction

    // lookup both words of the aligned pair
    always_comb begin
        slot_pc[0] = {i_lookup_pc[31:3], 3'b000};
        slot_pc[1] = {i_lookup_pc[31:3], 3'b100};
        for (int s = 0; s < 2; s++) begin
            slot_hit[s] = valid_q[pc_idx(slot_pc[s])] &&
                          (tag_mem[pc_idx(slot_pc[s])] == pc_tag(slot_pc[s]));
        end
        slot_hit[0] = slot_hit[0] & ~i_lookup_pc[2];   // entered at second word
    end

    assign o_pred_hit    = |slot_hit;
    assign o_pred_slot   = ~slot_hit[0];   // first hit wins
    assign o_pred_target = slot_hit[0] ? target_mem[pc_idx(slot_pc[0])]
                                       : target_mem[pc_idx(slot_pc[1])];

    ////////////////////////////////////////
    // update from branch resolution
    ////////////////////////////////////////
    assign upd_idx   = pc_idx(br.pc);
    assign upd_tag   = pc_tag(br.pc);
    assign upd_match = valid_q[upd_idx] && (tag_mem[upd_idx] == upd_tag);

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= '0;
        end else if (br.valid) begin
            if (br.taken) begin
                valid_q[upd_idx] <= 1'b1;
            end else if (upd_match) begin
                valid_q[upd_idx] <= 1'b0;   // not taken, evict own entry only
            end
        end
    end

    always_ff @(posedge clk) begin
        if (br.valid && br.taken) begin
            tag_mem[upd_idx]    <= upd_tag;
            target_mem[upd_idx] <= br.target;
        end
    end

endmodule

// File: source/fetch_ifs.sv
`timescale 1ns/1ps

// IF1 request, pc_gen -> axi_fetch
interface fetch_req_if;
    import fetch_pkg::*;

    logic  valid;
    logic  ready;
    addr_t pc;
    logic  pred_taken;
    addr_t pred_target;
    logic  pred_slot;

    modport src (
        output valid, pc, pred_taken, pred_target, pred_slot,
        input  ready
    );
    modport sink (
        input  valid, pc, pred_taken, pred_target, pred_slot,
        output ready
    );
endinterface

// fetched pair, axi_fetch -> fetch_queue
interface fetch_pair_if;
    import fetch_pkg::*;

    logic        valid;
    logic        ready;
    fetch_pair_t pair;

    modport src (
        output valid, pair,
        input  ready
    );
    modport sink (
        input  valid, pair,
        output ready
    );
endinterface

// branch resolution, single cycle pulse
interface br_update_if;
    import fetch_pkg::*;

    logic  valid;
    addr_t pc;
    addr_t target;
    logic  taken;
    logic  mispredict;

    modport ctrl (input valid, pc, target, taken, mispredict);
    modport btb  (input valid, pc, target, taken);
endinterface

// File: source/fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] addr_t;   // byte address
    typedef logic [31:0] instr_t;

    // one fetch pair as it travels to the decoder
    typedef struct packed {
        addr_t      pc;            // pair base, 8 byte aligned
        instr_t     inst0;
        instr_t     inst1;
        logic [1:0] slot_valid;    // bit 0 is slot 0
        logic       pred_taken;
        addr_t      pred_target;
        logic       pred_slot;     // slot that made the prediction
    } fetch_pair_t;

    ////////////////////////////////////////
    // AXI4 read channel constants
    ////////////////////////////////////////
    localparam int                  AXI_ID_W       = 4;
    localparam logic [AXI_ID_W-1:0] AXI_FETCH_ID   = '0;
    localparam logic [1:0]          AXI_BURST_INCR = 2'b01;
    localparam logic [2:0]          AXI_SIZE_WORD  = 3'b010;  // 4 bytes per beat
    localparam logic [7:0]          AXI_PAIR_LEN   = 8'd1;    // two beats
    localparam addr_t               PAIR_BYTES     = 32'd8;

    ////////////////////////////////////////
    // BTB address split
    ////////////////////////////////////////
    localparam int BTB_IDX_LSB = 2;    // index starts at the word bits
    localparam int BTB_TAG_W   = 12;   // partial tag above the index

endpackage

// File: source/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic              clk,
    input  logic              i_arst_n,
    fetch_pair_if.sink        pair,
    input  logic              i_flush,
    input  logic              i_inst_ready,
    output logic              o_inst_valid,
    output fetch_pkg::addr_t  o_inst_pc,
    output fetch_pkg::instr_t o_inst0,
    output fetch_pkg::instr_t o_inst1,
    output logic [1:0]        o_slot_valid,
    output logic              o_pred_taken,
    output fetch_pkg::addr_t  o_pred_target
);
    import fetch_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    fetch_pair_t    mem [QUEUE_DEPTH];
    logic [PTR_W:0] wr_ptr_q;   // extra wrap bit
    logic [PTR_W:0] rd_ptr_q;

    logic        full;
    logic        empty;
    logic        push;
    logic        pop;
    fetch_pair_t head;

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                   (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);
    assign push  = pair.valid & ~full & ~i_flush;
    assign pop   = ~empty & i_inst_ready;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else if (i_flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q[PTR_W-1:0]] <= pair.pair;
        end
    end

    assign head       = mem[rd_ptr_q[PTR_W-1:0]];
    assign pair.ready = ~full;

    ////////////////////////////////////////
    // decoder port
    ////////////////////////////////////////
    assign o_inst_valid  = ~empty;
    assign o_inst_pc     = head.pc;
    assign o_inst0       = head.inst0;
    assign o_inst1       = head.inst1;
    // slot 1 lies behind a taken slot 0 branch
    assign o_slot_valid  = head.slot_valid & {~(head.pred_taken & ~head.pred_slot), 1'b1};
    assign o_pred_taken  = head.pred_taken;
    assign o_pred_target = head.pred_target;

endmodule

// File: source/frontend_top.sv
`timescale 1ns/1ps

module frontend_top #(
    parameter fetch_pkg::addr_t RESET_PC    = 32'h1c00_0000,
    parameter int               BTB_ENTRIES = 16,
    parameter int               QUEUE_DEPTH = 4
) (
    input  logic                           clk,
    input  logic                           i_arst_n,
    // AXI4 read master
    output logic                           o_m_arvalid,
    output fetch_pkg::addr_t               o_m_araddr,
    output logic [7:0]                     o_m_arlen,
    output logic [2:0]                     o_m_arsize,
    output logic [1:0]                     o_m_arburst,
    output logic [fetch_pkg::AXI_ID_W-1:0] o_m_arid,
    input  logic                           i_m_arready,
    input  logic                           i_m_rvalid,
    input  fetch_pkg::instr_t              i_m_rdata,
    input  logic                           i_m_rlast,
    input  logic [fetch_pkg::AXI_ID_W-1:0] i_m_rid,
    output logic                           o_m_rready,
    // decoder port
    output logic                           o_inst_valid,
    input  logic                           i_inst_ready,
    output fetch_pkg::addr_t               o_inst_pc,
    output fetch_pkg::instr_t              o_inst0,
    output fetch_pkg::instr_t              o_inst1,
    output logic [1:0]                     o_slot_valid,
    output logic                           o_pred_taken,
    output fetch_pkg::addr_t               o_pred_target,
    // branch resolution
    input  logic                           i_br_valid,
    input  fetch_pkg::addr_t               i_br_pc,
    input  fetch_pkg::addr_t               i_br_target,
    input  logic                           i_br_taken,
    input  logic                           i_br_mispredict
);
    import fetch_pkg::*;

    fetch_req_if  u_req_if ();
    fetch_pair_if u_pair_if ();
    br_update_if  u_br_if ();

    addr_t lookup_pc;
    logic  pred_hit;
    addr_t pred_target;
    logic  pred_slot;
    logic  flush;

    assign u_br_if.valid      = i_br_valid;
    assign u_br_if.pc         = i_br_pc;
    assign u_br_if.target     = i_br_target;
    assign u_br_if.taken      = i_br_taken;
    assign u_br_if.mispredict = i_br_mispredict;

    assign flush = i_br_valid & i_br_mispredict;   // redirect from execute

    ////////////////////////////////////////
    // IF1
    ////////////////////////////////////////
    pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_pc_gen (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .br            (u_br_if.ctrl),
        .req           (u_req_if.src),
        .i_pred_hit    (pred_hit),
        .i_pred_target (pred_target),
        .i_pred_slot   (pred_slot),
        .o_lookup_pc   (lookup_pc)
    );

    branch_predictor #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) u_branch_predictor (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .br            (u_br_if.btb),
        .i_lookup_pc   (lookup_pc),
        .o_pred_hit    (pred_hit),
        .o_pred_target (pred_target),
        .o_pred_slot   (pred_slot)
    );

    ////////////////////////////////////////
    // IF2 and instruction buffer
    ////////////////////////////////////////
    axi_fetch u_axi_fetch (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .req         (u_req_if.sink),
        .pair        (u_pair_if.src),
        .i_flush     (flush),
        .o_m_arvalid (o_m_arvalid),
        .o_m_araddr  (o_m_araddr),
        .o_m_arlen   (o_m_arlen),
        .o_m_arsize  (o_m_arsize),
        .o_m_arburst (o_m_arburst),
        .o_m_arid    (o_m_arid),
        .i_m_arready (i_m_arready),
        .i_m_rvalid  (i_m_rvalid),
        .i_m_rdata   (i_m_rdata),
        .i_m_rlast   (i_m_rlast),
        .i_m_rid     (i_m_rid),
        .o_m_rready  (o_m_rready)
    );

    fetch_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_fetch_queue (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .pair          (u_pair_if.sink),
        .i_flush       (flush),
        .i_inst_ready  (i_inst_ready),
        .o_inst_valid  (o_inst_valid),
        .o_inst_pc     (o_inst_pc),
        .o_inst0       (o_inst0),
        .o_inst1       (o_inst1),
        .o_slot_valid  (o_slot_valid),
        .o_pred_taken  (o_pred_taken),
        .o_pred_target (o_pred_target)
    );

endmodule

// File: source/pc_gen.sv
`timescale 1ns/1ps

module pc_gen #(
    parameter fetch_pkg::addr_t RESET_PC = 32'h1c00_0000
) (
    input  logic             clk,
    input  logic             i_arst_n,
    br_update_if.ctrl        br,
    fetch_req_if.src         req,
    input  logic             i_pred_hit,
    input  fetch_pkg::addr_t i_pred_target,
    input  logic             i_pred_slot,
    output fetch_pkg::addr_t o_lookup_pc
);
    import fetch_pkg::*;

    addr_t pc_q;
    logic  req_valid_q;
    logic  hold_q;          // request stalled last cycle
    logic  hold_hit_q;
    addr_t hold_target_q;
    logic  hold_slot_q;

    logic  flush;
    logic  fire;
    addr_t redirect_pc;
    addr_t seq_pc;
    logic  pred_hit;
    addr_t pred_target;
    logic  pred_slot;

    assign flush       = br.valid & br.mispredict;
    assign fire        = req.valid & req.ready;
    assign redirect_pc = br.taken ? br.target : br.pc + 32'd4;
    assign seq_pc      = {pc_q[31:3], 3'b000} + PAIR_BYTES;

    // keep the prediction frozen while the request waits,
    // a BTB write must not change a pending payload
    assign pred_hit    = hold_q ? hold_hit_q    : i_pred_hit;
    assign pred_target = hold_q ? hold_target_q : i_pred_target;
    assign pred_slot   = hold_q ? hold_slot_q   : i_pred_slot;

    ////////////////////////////////////////
    // IF1 PC register
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q        <= RESET_PC;
            req_valid_q <= 1'b0;
            hold_q      <= 1'b0;
        end else begin
            req_valid_q <= 1'b1;
            hold_q      <= req_valid_q & ~req.ready & ~flush;
            if (flush) begin
                pc_q <= redirect_pc;
            end else if (fire) begin
                pc_q <= pred_hit ? pred_target : seq_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        hold_hit_q    <= pred_hit;
        hold_target_q <= pred_target;
        hold_slot_q   <= pred_slot;
    end

    assign req.valid       = req_valid_q;
    assign req.pc          = pc_q;
    assign req.pred_taken  = pred_hit;
    assign req.pred_target = pred_target;
    assign req.pred_slot   = pred_slot;
    assign o_lookup_pc     = pc_q;

endmodule

// File: vlog.f
source/fetch_pkg.sv
source/fetch_ifs.sv
source/branch_predictor.sv
source/pc_gen.sv
source/axi_fetch.sv
source/fetch_queue.sv
source/frontend_top.sv
sim/frontend_assertions.sv
sim/tb_frontend.sv
